// File: rtl/mem_check_pkg.sv
// Shared definitions for the data-memory bus conformance monitor
// Bus widths, expectation queue sizing, outstanding counter width
// and the record of one access predicted by the reference model

package mem_check_pkg;

  // Data bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;  // One enable per byte lane

  // Expectation queue sizing
  localparam int EXP_DEPTH = 4;
  localparam int EXP_PTR_W = (EXP_DEPTH > 1) ? $clog2(EXP_DEPTH) : 1;
  localparam int EXP_CNT_W = $clog2(EXP_DEPTH + 1);  // Must hold the value EXP_DEPTH

  // Outstanding request counter width
  localparam int OUTST_W = 8;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [BE_W-1:0]    be_t;
  typedef logic [OUTST_W-1:0] outst_cnt_t;

  localparam outst_cnt_t OUTST_MAX = '1;  // Saturation point of the counter

  // One expected access as predicted by the model
  // A misaligned access is split into a first and a second bus request
  // The snd_* fields only mean something when has_snd is set
  typedef struct packed {
    logic  is_write;   // Store when set, load otherwise
    logic  has_snd;    // Access needs a second request
    addr_t fst_addr;
    addr_t snd_addr;
    data_t fst_wdata;
    data_t snd_wdata;
    be_t   fst_be;     // Lanes that carry real store data
    be_t   snd_be;
  } exp_access_t;

  // Which request of the head access the next grant belongs to
  typedef enum logic {
    PHASE_FST = 1'b0,
    PHASE_SND = 1'b1
  } phase_e;

endpackage

// File: rtl/mem_bus_if.sv
// Data-memory bus signal group
// Carries request, grant and response of the observed bus; the
// checker blocks only look at it, so every modport is input only

`timescale 1ns/1ps

interface mem_bus_if;
  import mem_check_pkg::*;

  logic  req;     // Request from the master
  logic  gnt;     // Request accepted by the memory
  logic  rvalid;  // Response this cycle
  logic  we;      // Request is a write
  be_t   be;
  addr_t addr;
  data_t wdata;
  logic  err;     // Response carries an error

  // Passive view for all observers
  modport monitor (
    input req,
    input gnt,
    input rvalid,
    input we,
    input be,
    input addr,
    input wdata,
    input err
  );

endinterface

// File: rtl/outstanding_tracker.sv
// Outstanding request tracker
// Counts granted requests still waiting for their response, saturates
// at both ends and flags stray responses and counter overflow

`timescale 1ns/1ps

module outstanding_tracker (
  input  logic                    clk_i,
  input  logic                    reset_i,
  mem_bus_if.monitor              bus,
  output mem_check_pkg::outst_cnt_t outstanding_o,
  output logic                    stray_resp_o,
  output logic                    overflow_o
);
  import mem_check_pkg::*;

  logic       grant;
  logic       resp;
  outst_cnt_t count_q;
  logic       stray_q;
  logic       overflow_q;

  assign grant = bus.req && bus.gnt;  // Request leaves in this cycle
  assign resp  = bus.rvalid;          // One response retires one request

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q    <= '0;
      stray_q    <= 1'b0;
      overflow_q <= 1'b0;
    end else begin
      // A grant in the same cycle covers the response, so no stray then
      stray_q    <= resp && !grant && (count_q == '0);
      overflow_q <= grant && !resp && (count_q == OUTST_MAX);
      case ({grant, resp})
        2'b10: begin
          if (count_q != OUTST_MAX) begin
            count_q <= count_q + 1'b1;
          end
        end
        2'b01: begin
          if (count_q != '0) begin
            count_q <= count_q - 1'b1;
          end
        end
        default: begin
          count_q <= count_q;  // Idle, or grant and response cancel out
        end
      endcase
    end
  end

  assign outstanding_o = count_q;
  assign stray_resp_o  = stray_q;
  assign overflow_o    = overflow_q;

  // Error is a qualifier of the response and means nothing on its own
  err_with_rvalid_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    bus.err |-> bus.rvalid
  );

  // Saturation must hold in both directions
  no_wrap_up_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (count_q == OUTST_MAX) |=> (count_q != '0)
  );

  no_wrap_down_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (count_q == '0) |=> (count_q != OUTST_MAX)
  );

endmodule

// File: rtl/expect_fifo.sv
// Expectation queue
// Circular buffer of accesses predicted by the reference model, in
// program order; the head is what the next bus request is held against

`timescale 1ns/1ps

module expect_fifo (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        push_valid_i,
  input  mem_check_pkg::exp_access_t  push_data_i,
  output logic                        push_ready_o,
  input  logic                        pop_i,
  output mem_check_pkg::exp_access_t  head_o,
  output logic                        not_empty_o
);
  import mem_check_pkg::*;

  typedef logic [EXP_PTR_W-1:0] ptr_t;
  typedef logic [EXP_CNT_W-1:0] cnt_t;

  exp_access_t mem_q [EXP_DEPTH];  // Entry storage
  ptr_t        wr_ptr_q;
  ptr_t        rd_ptr_q;
  cnt_t        count_q;
  logic        full;
  logic        push;

  assign full         = (count_q == cnt_t'(EXP_DEPTH));
  assign push_ready_o = !full || pop_i;  // Head leaving frees a slot this cycle
  assign push         = push_valid_i && push_ready_o;
  assign not_empty_o  = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Pointers wrap at EXP_DEPTH, which need not be a power of two
        wr_ptr_q <= (wr_ptr_q == ptr_t'(EXP_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(EXP_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + cnt_t'(push) - cnt_t'(pop_i);  // Net zero on push plus pop
    end
  end

  // Sequencer only pops an access that is actually queued
  no_pop_empty_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    pop_i |-> not_empty_o
  );

  // Occupancy never climbs past the depth of the buffer
  no_push_full_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    count_q <= cnt_t'(EXP_DEPTH)
  );

endmodule

// File: rtl/access_sequencer.sv
// Access sequencer
// Follows the head access through its first granted request and, for
// a split access, the second one; pops the head once it is complete

`timescale 1ns/1ps

module access_sequencer (
  input  logic                  clk_i,
  input  logic                  reset_i,
  mem_bus_if.monitor            bus,
  input  logic                  head_has_snd_i,
  input  logic                  not_empty_i,
  output mem_check_pkg::phase_e phase_o,
  output logic                  pop_o
);
  import mem_check_pkg::*;

  phase_e phase_q;
  logic   grant;
  logic   tracked_grant;  // Grant that belongs to a queued access
  logic   last_req;       // Current request completes the access

  assign grant         = bus.req && bus.gnt;
  assign tracked_grant = grant && not_empty_i;  // Empty queue grants leave state alone

  // Unsplit access ends at its first grant, split one at its second
  assign last_req = (phase_q == PHASE_SND) || !head_has_snd_i;
  assign pop_o    = tracked_grant && last_req;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      phase_q <= PHASE_FST;
    end else if (tracked_grant) begin
      if (last_req) begin
        phase_q <= PHASE_FST;  // Next grant starts a new access
      end else begin
        phase_q <= PHASE_SND;  // First half of a misaligned access done
      end
    end
  end

  assign phase_o = phase_q;

  // Second phase implies the split access is still at the queue head
  snd_needs_head_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (phase_q == PHASE_SND) |-> not_empty_i
  );

  snd_head_split_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (phase_q == PHASE_SND) |-> head_has_snd_i
  );

endmodule

// File: rtl/req_comparator.sv
// Request comparator
// Holds each granted request against the expected phase of the head
// access and registers the verdict for the following cycle

`timescale 1ns/1ps

module req_comparator (
  input  logic                       clk_i,
  input  logic                       reset_i,
  mem_bus_if.monitor                 bus,
  input  mem_check_pkg::exp_access_t head_i,
  input  logic                       not_empty_i,
  input  mem_check_pkg::phase_e      phase_i,
  output logic                       check_valid_o,
  output logic                       check_ok_o,
  output mem_check_pkg::phase_e      check_phase_o,
  output logic                       unexpected_o
);
  import mem_check_pkg::*;

  addr_t  exp_addr;
  data_t  exp_wdata;
  be_t    exp_be;
  data_t  exp_mask;    // Byte enables widened to bit lanes
  logic   grant;
  logic   dir_ok;
  logic   addr_ok;
  logic   data_ok;
  logic   valid_q;
  logic   unexp_q;
  logic   ok_q;        // Verdict payload, only read with valid_q
  phase_e phase_q;

  assign grant = bus.req && bus.gnt;

  // Pick the half of the access the current grant belongs to
  always_comb begin
    if (phase_i == PHASE_SND) begin
      exp_addr  = head_i.snd_addr;
      exp_wdata = head_i.snd_wdata;
      exp_be    = head_i.snd_be;
    end else begin
      exp_addr  = head_i.fst_addr;
      exp_wdata = head_i.fst_wdata;
      exp_be    = head_i.fst_be;
    end
  end

  always_comb begin
    for (int b = 0; b < BE_W; b++) begin
      exp_mask[8*b +: 8] = {8{exp_be[b]}};
    end
  end

  assign dir_ok  = (bus.we == head_i.is_write);
  assign addr_ok = (bus.addr == exp_addr);
  // Disabled lanes may carry anything; enables are not compared
  assign data_ok = !bus.we || ((bus.wdata & exp_mask) == (exp_wdata & exp_mask));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
      unexp_q <= 1'b0;
    end else begin
      valid_q <= grant && not_empty_i;
      unexp_q <= grant && !not_empty_i;  // Nothing predicted for this request
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant && not_empty_i) begin
      ok_q    <= dir_ok && addr_ok && data_ok;
      phase_q <= phase_i;
    end
  end

  assign check_valid_o = valid_q;
  assign check_ok_o    = ok_q;
  assign check_phase_o = phase_q;
  assign unexpected_o  = unexp_q;

  // A granted store always writes at least one byte lane
  write_has_be_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (grant && bus.we) |-> (bus.be != '0)
  );

endmodule

// File: rtl/mem_conformance_checker.sv
// Data-memory bus conformance checker, top level
// Observes request, grant and response of the bus, checks each granted
// request against the queued model predictions and tracks outstanding
// requests

`timescale 1ns/1ps

module mem_conformance_checker (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // Observed data bus
  input  logic                       data_req_i,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic                       data_we_i,
  input  mem_check_pkg::be_t         data_be_i,
  input  mem_check_pkg::addr_t       data_addr_i,
  input  mem_check_pkg::data_t       data_wdata_i,
  input  logic                       data_err_i,
  // Model predictions
  input  logic                       exp_valid_i,
  input  mem_check_pkg::exp_access_t exp_i,
  output logic                       exp_ready_o,
  // Results
  output logic                       check_valid_o,
  output logic                       check_ok_o,
  output mem_check_pkg::phase_e      check_phase_o,
  output logic                       unexpected_o,
  output mem_check_pkg::outst_cnt_t  outstanding_o,
  output logic                       stray_resp_o,
  output logic                       overflow_o
);
  import mem_check_pkg::*;

  exp_access_t head;       // Oldest pending prediction
  logic        not_empty;
  logic        pop;
  phase_e      phase;

  mem_bus_if bus ();

  assign bus.req    = data_req_i;
  assign bus.gnt    = data_gnt_i;
  assign bus.rvalid = data_rvalid_i;
  assign bus.we     = data_we_i;
  assign bus.be     = data_be_i;
  assign bus.addr   = data_addr_i;
  assign bus.wdata  = data_wdata_i;
  assign bus.err    = data_err_i;

  outstanding_tracker u_outstanding_tracker (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bus           (bus),
    .outstanding_o (outstanding_o),
    .stray_resp_o  (stray_resp_o),
    .overflow_o    (overflow_o)
  );

  expect_fifo u_expect_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_valid_i (exp_valid_i),
    .push_data_i  (exp_i),
    .push_ready_o (exp_ready_o),
    .pop_i        (pop),
    .head_o       (head),
    .not_empty_o  (not_empty)
  );

  access_sequencer u_access_sequencer (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .bus            (bus),
    .head_has_snd_i (head.has_snd),
    .not_empty_i    (not_empty),
    .phase_o        (phase),
    .pop_o          (pop)
  );

  req_comparator u_req_comparator (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .bus           (bus),
    .head_i        (head),
    .not_empty_i   (not_empty),
    .phase_i       (phase),
    .check_valid_o (check_valid_o),
    .check_ok_o    (check_ok_o),
    .check_phase_o (check_phase_o),
    .unexpected_o  (unexpected_o)
  );

endmodule

// File: bench/tb_mem_conformance_checker.sv
// Testbench for the data-memory bus conformance checker
// Drives random accesses from a fixed seed and checks every cycle
// against a queue model of the expected verdicts and counters

`timescale 1ns/1ps

module tb_mem_conformance_checker;
  import mem_check_pkg::*;

  localparam int RESET_CYC   = 8;
  localparam int T1_CYC      = 24;   // 12 rounds of push then grant
  localparam int T2_CYC      = 48;   // 6 rounds of 4 variants
  localparam int T3_CYC      = 12;
  localparam int T4_CYC      = 12;
  localparam int T5_CYC      = 456;  // Drain of a full count plus 200 random cycles
  localparam int CYCLE_LIMIT = RESET_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + 100;

  logic        clk_i;
  logic        reset_i;
  logic        data_req_i, data_gnt_i, data_rvalid_i, data_we_i, data_err_i;
  be_t         data_be_i;
  addr_t       data_addr_i;
  data_t       data_wdata_i;
  logic        exp_valid_i;
  exp_access_t exp_i;
  logic        exp_ready_o, check_valid_o, check_ok_o, unexpected_o;
  phase_e      check_phase_o;
  outst_cnt_t  outstanding_o;
  logic        stray_resp_o, overflow_o;

  // Model state
  exp_access_t model_q[$];
  phase_e      m_phase = PHASE_FST;
  outst_cnt_t  m_count = '0;
  bit          pred_valid, pred_ok, pred_unexp, pred_stray, pred_ovf;
  phase_e      pred_phase;
  int          err_cnt = 0, check_cnt = 0, cycle_cnt = 0;
  int          test_cnt = 0, test_fail = 0, err_base = 0, stray_hits = 0;

  mem_conformance_checker DUT (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout, run went past %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_flag(input string name, input bit got, input bit exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_count(input string name, input outst_cnt_t got, input outst_cnt_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_verdict(input bit got_ok, input phase_e got_ph, input bit exp_ok,
                               input phase_e exp_ph);
    check_flag("check_ok_o", got_ok, exp_ok);
    check_cnt++;
    if (got_ph !== exp_ph) begin
      err_cnt++;
      $display("ERR check_phase_o got 0x%0h expected 0x%0h at %0t", got_ph, exp_ph, $time);
    end
  endtask

  // Only lanes enabled in the expected access take part in the data compare
  function automatic bit expected_ok(input exp_access_t e, input phase_e ph, input logic we,
                                     input addr_t addr, input data_t wdata);
    addr_t a;
    data_t d;
    be_t   be;
    bit    ok;
    a  = (ph == PHASE_SND) ? e.snd_addr : e.fst_addr;
    d  = (ph == PHASE_SND) ? e.snd_wdata : e.fst_wdata;
    be = (ph == PHASE_SND) ? e.snd_be : e.fst_be;
    ok = (we == e.is_write) && (addr == a);
    if (we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be[b] && (wdata[8*b +: 8] != d[8*b +: 8])) ok = 1'b0;
      end
    end
    return ok;
  endfunction

  function automatic exp_access_t rand_access(input bit split);
    exp_access_t e;
    e.is_write  = 1'($urandom_range(1, 0));
    e.has_snd   = split;
    e.fst_addr  = addr_t'($urandom);
    e.snd_addr  = addr_t'($urandom);
    e.fst_wdata = data_t'($urandom);
    e.snd_wdata = data_t'($urandom);
    e.fst_be    = be_t'($urandom_range(15, 1));  // A store always writes at least one lane
    e.snd_be    = be_t'($urandom_range(15, 1));
    return e;
  endfunction

  // Predict from the inputs now on the bus and compare after the next edge
  task automatic clock_cycle();
    bit          grant, resp, tracked, pop, ready, push;
    exp_access_t head;
    #2;
    grant      = data_req_i && data_gnt_i;
    resp       = data_rvalid_i;
    tracked    = grant && (model_q.size() != 0);
    pop        = 1'b0;
    pred_valid = tracked;
    pred_unexp = grant && !tracked;  // Nothing queued for this request
    if (tracked) begin
      head       = model_q[0];
      pred_ok    = expected_ok(head, m_phase, data_we_i, data_addr_i, data_wdata_i);
      pred_phase = m_phase;
      if (m_phase == PHASE_SND || !head.has_snd) begin
        pop     = 1'b1;
        m_phase = PHASE_FST;
      end else begin
        m_phase = PHASE_SND;
      end
    end
    ready = (model_q.size() < EXP_DEPTH) || pop;
    check_flag("exp_ready_o", exp_ready_o, ready);
    push = exp_valid_i && ready;
    if (pop) void'(model_q.pop_front());
    if (push) model_q.push_back(exp_i);
    pred_stray = resp && !grant && (m_count == '0);
    pred_ovf   = grant && !resp && (m_count == OUTST_MAX);
    if (grant && !resp && m_count != OUTST_MAX) m_count = m_count + 8'd1;
    else if (resp && !grant && m_count != '0) m_count = m_count - 8'd1;
    @(posedge clk_i);
    #1;
    check_flag("check_valid_o", check_valid_o, pred_valid);
    if (pred_valid) check_verdict(check_ok_o, check_phase_o, pred_ok, pred_phase);
    check_flag("unexpected_o", unexpected_o, pred_unexp);
    check_count("outstanding_o", outstanding_o, m_count);
    check_flag("stray_resp_o", stray_resp_o, pred_stray);
    check_flag("overflow_o", overflow_o, pred_ovf);
    stray_hits += int'(pred_stray);
  endtask

  task automatic push_access(input exp_access_t e);
    exp_valid_i = 1'b1;
    exp_i       = e;
    clock_cycle();
    exp_valid_i = 1'b0;
  endtask

  task automatic grant_req(input logic we, input be_t be, input addr_t addr, input data_t wd);
    data_req_i   = 1'b1;
    data_gnt_i   = 1'b1;
    data_we_i    = we;
    data_be_i    = be;
    data_addr_i  = addr;
    data_wdata_i = wd;
    clock_cycle();
    data_req_i = 1'b0;
    data_gnt_i = 1'b0;
    data_we_i  = 1'b0;
  endtask

  // Request that agrees with the head access in its current phase
  task automatic grant_head();
    exp_access_t e;
    e = model_q[0];
    if (m_phase == PHASE_SND) grant_req(e.is_write, e.snd_be, e.snd_addr, e.snd_wdata);
    else grant_req(e.is_write, e.fst_be, e.fst_addr, e.fst_wdata);
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt != err_base) test_fail++;
    $display("test %0d %s: %s, %0d errors", test_cnt, name,
             (err_cnt == err_base) ? "ok" : "mismatch", err_cnt - err_base);
    err_base = err_cnt;
  endtask

  initial begin
    exp_access_t e;
    data_t       noise;
    int          lane;
    void'($urandom(32'h9249_0c1d));
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    data_req_i    = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_we_i     = 1'b0;
    data_err_i    = 1'b0;
    data_be_i     = '0;
    data_addr_i   = '0;
    data_wdata_i  = '0;
    exp_valid_i   = 1'b0;
    exp_i         = '0;
    repeat (RESET_CYC) @(posedge clk_i);
    #1 reset_i = 1'b0;
    check_flag("exp_ready_o", exp_ready_o, 1'b1);  // Empty queue after reset
    check_flag("check_valid_o", check_valid_o, 1'b0);
    check_flag("unexpected_o", unexpected_o, 1'b0);
    check_count("outstanding_o", outstanding_o, '0);
    check_flag("stray_resp_o", stray_resp_o, 1'b0);
    check_flag("overflow_o", overflow_o, 1'b0);

    for (int i = 0; i < 12; i++) begin
      push_access(rand_access(1'b0));
      grant_head();
    end
    finish_test("single accesses");

    for (int i = 0; i < 6; i++) begin
      e = rand_access(1'b0);
      e.is_write = 1'b1;
      push_access(e);
      noise = data_t'($urandom);
      for (int b = 0; b < BE_W; b++) if (e.fst_be[b]) noise[8*b +: 8] = 8'h00;
      grant_req(1'b1, e.fst_be, e.fst_addr, e.fst_wdata ^ noise);  // Disabled lanes only
      push_access(e);
      lane = 0;
      while (!e.fst_be[lane]) lane++;
      noise = '0;
      noise[8*lane +: 8] = 8'($urandom_range(255, 1));
      grant_req(1'b1, e.fst_be, e.fst_addr, e.fst_wdata ^ noise);  // Enabled lane differs
      push_access(e);
      grant_req(1'b0, e.fst_be, e.fst_addr, e.fst_wdata);          // Wrong direction
      push_access(e);
      grant_req(1'b1, e.fst_be, e.fst_addr ^ 32'h4, e.fst_wdata);  // Wrong address
    end
    finish_test("masked write data");

    for (int i = 0; i < EXP_DEPTH; i++) push_access(rand_access(1'b1));
    while (model_q.size() != 0) grant_head();  // Ready stays low until a second grant
    finish_test("split accesses");

    while (model_q.size() < EXP_DEPTH) push_access(rand_access(1'b0));
    push_access(rand_access(1'b0));  // Refused while the queue is full
    while (model_q.size() != 0) grant_head();
    for (int i = 0; i < 3; i++) grant_req(1'b0, '0, addr_t'($urandom), '0);
    finish_test("back-pressure and unexpected grants");

    data_rvalid_i = 1'b1;
    while (m_count != '0) clock_cycle();  // Retire what the earlier tests left
    stray_hits = 0;
    for (int i = 0; i < 200; i++) begin
      data_req_i    = ($urandom_range(2, 0) == 0);
      data_gnt_i    = 1'($urandom_range(1, 0));
      data_rvalid_i = 1'($urandom_range(1, 0));
      data_addr_i   = addr_t'($urandom);
      clock_cycle();
    end
    data_req_i    = 1'b0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    if (stray_hits == 0) begin
      err_cnt++;
      $display("Random traffic never produced a response at zero count");
    end
    finish_test("outstanding count");

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             test_cnt, test_fail, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: mem_conformance_checker.f
rtl/mem_check_pkg.sv
rtl/mem_bus_if.sv
rtl/outstanding_tracker.sv
rtl/expect_fifo.sv
rtl/access_sequencer.sv
rtl/req_comparator.sv
rtl/mem_conformance_checker.sv
bench/tb_mem_conformance_checker.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the conformance checker testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f mem_conformance_checker.f \
  --top-module tb_mem_conformance_checker \
  -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB PASSED" "$SIM_LOG"; then
  exit 0
else
  echo "Pass message not found in $SIM_LOG"
  exit 1
fi
